// File: Makefile
TOP := tb_clint_subsystem

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f clint_subsystem.f -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// File: clint/clint_apb_decoder.sv
`timescale 1ns/1ns

module clint_apb_decoder #(
  parameter int unsigned NumHarts = 2
) (
  input  logic                                              clk_i,
  input  logic                                              ndmreset_n,
  input  logic                                              psel_i,
  input  logic                                              penable_i,
  input  logic                                              pwrite_i,
  input  logic [clint_pkg::ApbAddrWidth-1:0]                paddr_i,
  input  logic [clint_pkg::ApbDataWidth-1:0]                pwdata_i,
  input  logic [NumHarts-1:0][clint_pkg::ApbDataWidth-1:0]  hart_rdata_i,
  input  logic [clint_pkg::MtimeWidth-1:0]                  mtime_i,
  output logic                                              pready_o,
  output logic [clint_pkg::ApbDataWidth-1:0]                prdata_o,
  output logic                                              pslverr_o,
  output logic [NumHarts-1:0]                               hart_wr_o,
  output clint_pkg::reg_sel_e                               reg_sel_o,
  output logic [clint_pkg::ApbDataWidth-1:0]                wdata_o,
  output logic                                              mtime_wr_lo_o,
  output logic                                              mtime_wr_hi_o
);

  localparam int unsigned HartIdxWidth = (NumHarts > 1) ? $clog2(NumHarts) : 1;
  localparam int unsigned MsipEnd = 32'(clint_pkg::MsipBase) + 4 * NumHarts;
  localparam int unsigned CmpEnd  = 32'(clint_pkg::MtimecmpBase) + 8 * NumHarts;

  clint_pkg::apb_phase_e               phase_q, phase_d;
  logic [31:0]                         addr_ext;
  logic [31:0]                         cmp_off;
  logic [HartIdxWidth-1:0]             hart_idx;
  logic                                hart_reg;
  logic                                wr_commit;
  logic [clint_pkg::ApbDataWidth-1:0]  rdata_mux;
  logic [clint_pkg::ApbDataWidth-1:0]  prdata_q;
  logic                                err_q;

  assign addr_ext = {{(32 - clint_pkg::ApbAddrWidth){1'b0}}, paddr_i};
  assign cmp_off  = addr_ext - 32'(clint_pkg::MtimecmpBase);

  // --------------------
  // Address decode
  // --------------------
  always_comb begin
    reg_sel_o = clint_pkg::REG_NONE;
    hart_idx  = '0;
    if (paddr_i[1:0] == 2'b00) begin
      if (addr_ext >= 32'(clint_pkg::MsipBase) && addr_ext < MsipEnd) begin
        reg_sel_o = clint_pkg::REG_MSIP;
        hart_idx  = addr_ext[HartIdxWidth+1:2];
      end else if (addr_ext >= 32'(clint_pkg::MtimecmpBase) && addr_ext < CmpEnd) begin
        reg_sel_o = cmp_off[2] ? clint_pkg::REG_MTIMECMP_HI : clint_pkg::REG_MTIMECMP_LO;
        hart_idx  = cmp_off[HartIdxWidth+2:3];
      end else if (paddr_i == clint_pkg::MtimeLoAddr) begin
        reg_sel_o = clint_pkg::REG_MTIME_LO;
      end else if (paddr_i == clint_pkg::MtimeHiAddr) begin
        reg_sel_o = clint_pkg::REG_MTIME_HI;
      end
    end
  end

  assign hart_reg = reg_sel_o inside {clint_pkg::REG_MSIP, clint_pkg::REG_MTIMECMP_LO,
                                      clint_pkg::REG_MTIMECMP_HI};

  // Writes land in the first access cycle
  assign wr_commit = (phase_q == clint_pkg::PH_WAIT) && psel_i && penable_i && pwrite_i;

  always_comb begin
    hart_wr_o = '0;
    if (wr_commit && hart_reg) begin
      hart_wr_o[hart_idx] = 1'b1;
    end
  end

  assign mtime_wr_lo_o = wr_commit && (reg_sel_o == clint_pkg::REG_MTIME_LO);
  assign mtime_wr_hi_o = wr_commit && (reg_sel_o == clint_pkg::REG_MTIME_HI);
  assign wdata_o       = pwdata_i;

  always_comb begin
    case (reg_sel_o)
      clint_pkg::REG_MTIME_LO: rdata_mux = mtime_i[31:0];
      clint_pkg::REG_MTIME_HI: rdata_mux = mtime_i[63:32];
      clint_pkg::REG_NONE:     rdata_mux = '0;
      default:                 rdata_mux = hart_rdata_i[hart_idx];
    endcase
  end

  // --------------------
  // Transfer FSM
  // --------------------
  always_comb begin
    phase_d = phase_q;
    case (phase_q)
      clint_pkg::PH_IDLE: if (psel_i && !penable_i) phase_d = clint_pkg::PH_WAIT;
      clint_pkg::PH_WAIT: phase_d = (psel_i && penable_i) ? clint_pkg::PH_DONE
                                                           : clint_pkg::PH_IDLE;
      default:            phase_d = clint_pkg::PH_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      phase_q <= clint_pkg::PH_IDLE;
      err_q   <= 1'b0;
    end else begin
      phase_q <= phase_d;
      if (phase_q == clint_pkg::PH_WAIT) begin
        err_q <= (reg_sel_o == clint_pkg::REG_NONE);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (phase_q == clint_pkg::PH_WAIT) begin
      prdata_q <= rdata_mux;
    end
  end

  assign pready_o  = (phase_q == clint_pkg::PH_DONE);
  assign prdata_o  = prdata_q;
  assign pslverr_o = pready_o && err_q;

  a_penable_needs_psel: assert property (
    @(posedge clk_i) disable iff (!ndmreset_n) penable_i |-> psel_i);

  a_addr_stable: assert property (
    @(posedge clk_i) disable iff (!ndmreset_n)
    (psel_i && penable_i && !pready_o) |=> $stable(paddr_i));

endmodule

// File: clint/clint_hart_timer.sv
`timescale 1ns/1ns

module clint_hart_timer (
  input  logic                               clk_i,
  input  logic                               ndmreset_n,
  input  logic                               wr_i,
  input  clint_pkg::reg_sel_e                reg_sel_i,
  input  logic [clint_pkg::ApbDataWidth-1:0] wdata_i,
  input  logic [clint_pkg::MtimeWidth-1:0]   mtime_i,
  output logic [clint_pkg::ApbDataWidth-1:0] rdata_o,
  output logic                               timer_hit_o,
  output logic                               msip_o
);

  logic [clint_pkg::MtimeWidth-1:0] mtimecmp_q;
  logic                             msip_q;

  // Compare resets to all ones so it stays quiet
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      mtimecmp_q <= '1;
      msip_q     <= 1'b0;
    end else if (wr_i) begin
      case (reg_sel_i)
        clint_pkg::REG_MSIP:        msip_q            <= wdata_i[0];
        clint_pkg::REG_MTIMECMP_LO: mtimecmp_q[31:0]  <= wdata_i;
        clint_pkg::REG_MTIMECMP_HI: mtimecmp_q[63:32] <= wdata_i;
        default: ;
      endcase
    end
  end

  always_comb begin
    case (reg_sel_i)
      clint_pkg::REG_MSIP:        rdata_o = {{(clint_pkg::ApbDataWidth - 1){1'b0}}, msip_q};
      clint_pkg::REG_MTIMECMP_LO: rdata_o = mtimecmp_q[31:0];
      clint_pkg::REG_MTIMECMP_HI: rdata_o = mtimecmp_q[63:32];
      default:                    rdata_o = '0;
    endcase
  end

  // Unsigned compare
  assign timer_hit_o = (mtime_i >= mtimecmp_q);
  assign msip_o      = msip_q;

  // The decoder must never route a timer write here
  a_no_mtime_write: assert property (
    @(posedge clk_i) disable iff (!ndmreset_n)
    wr_i |-> !(reg_sel_i inside {clint_pkg::REG_MTIME_LO, clint_pkg::REG_MTIME_HI}));

endmodule

// File: clint_subsystem.f
common/clint_pkg.sv
clint/clint_apb_decoder.sv
clint/clint_hart_timer.sv
source/mtime_counter.sv
source/irq_collector.sv
source/clint_subsystem.sv
dv/tb_clock_gen.sv
dv/tb_clint_subsystem.sv

// File: common/clint_pkg.sv
package clint_pkg;

  // --------------------
  // Bus and timer widths
  // --------------------
  localparam int unsigned ApbAddrWidth = 16;
  localparam int unsigned ApbDataWidth = 32;
  localparam int unsigned MtimeWidth   = 64;

  // --------------------
  // Register map
  // --------------------
  // One msip word per hart, stride 4
  localparam logic [ApbAddrWidth-1:0] MsipBase     = 16'h0000;
  // Compare registers, stride 8, low half first
  localparam logic [ApbAddrWidth-1:0] MtimecmpBase = 16'h4000;
  localparam logic [ApbAddrWidth-1:0] MtimeLoAddr  = 16'hBFF8;
  localparam logic [ApbAddrWidth-1:0] MtimeHiAddr  = 16'hBFFC;

  // Target of a decoded access
  typedef enum logic [2:0] {
    REG_NONE,
    REG_MSIP,
    REG_MTIMECMP_LO,
    REG_MTIMECMP_HI,
    REG_MTIME_LO,
    REG_MTIME_HI
  } reg_sel_e;

  // Decoder FSM, one wait state per transfer
  typedef enum logic [1:0] {
    PH_IDLE,
    PH_WAIT,
    PH_DONE
  } apb_phase_e;

endpackage

// File: dv/clint_input.txt
# W addr data err | R addr exp_data exp_err | T rtc_edges (decimal)
# I exp_timer_irq exp_ipi (bit h is hart h) | D debug hold-off; other values hex
D
R 4000 ffffffff 0
R 400c ffffffff 0
I 0 0
W 4000 00000100 0
W 4004 00000000 0
W 4008 12345678 0
W 400c 9abcdef0 0
R 4000 00000100 0
R 4004 00000000 0
R 4008 12345678 0
R 400c 9abcdef0 0
W 0000 fffffffe 0
W 0004 00000003 0
R 0000 00000000 0
R 0004 00000001 0
I 0 2
W 0000 00000001 0
W 0004 00000000 0
I 0 1
W bff8 000000fc 0
R bff8 000000fc 0
I 0 1
T 8
R bff8 00000100 0
R bffc 00000000 0
I 1 1
W bffc 9abcdef0 0
R bffc 9abcdef0 0
I 1 1
W bff8 12345678 0
I 3 1
W 0008 ffffffff 1
W 4010 00000000 1
W 0002 00000001 1
R 8000 00000000 1
R 0008 00000000 1
R 0000 00000001 0
R 400c 9abcdef0 0
R bff8 12345678 0

// File: dv/tb_clint_subsystem.sv
`timescale 1ns/1ns

module tb_clint_subsystem;

  localparam int unsigned NumHarts      = 2;
  localparam int unsigned HoldoffCycles = 40;

  logic                clk;
  logic                ndmreset_n;
  logic                rtc;
  logic                psel;
  logic                penable;
  logic                pwrite;
  logic [15:0]         paddr;
  logic [31:0]         pwdata;
  logic [NumHarts-1:0] debug_req;
  logic                pready;
  logic [31:0]         prdata;
  logic                pslverr;
  logic [NumHarts-1:0] timer_irq;
  logic [NumHarts-1:0] ipi;
  logic [NumHarts-1:0] debug_req_out;

  int unsigned run_cycles = 0;
  int unsigned rel_cycles = 0;
  int unsigned max_cycles = 32'd1_000_000;
  int          err_cnt    = 0;
  int          test_cnt   = 0;

  tb_clock_gen #(
    .PeriodNs     ( 100        ),
    .ResetCycles  ( 3          )
  ) i_tb_clock_gen (
    .clk_o        ( clk        ),
    .ndmreset_n_o ( ndmreset_n )
  );

  clint_subsystem #(
    .NumHarts         ( NumHarts      ),
    .DbgHoldoffCycles ( HoldoffCycles )
  ) clint_subsystem_i (
    .clk_i       ( clk           ),
    .ndmreset_n  ( ndmreset_n    ),
    .rtc_i       ( rtc           ),
    .psel_i      ( psel          ),
    .penable_i   ( penable       ),
    .pwrite_i    ( pwrite        ),
    .paddr_i     ( paddr         ),
    .pwdata_i    ( pwdata        ),
    .debug_req_i ( debug_req     ),
    .pready_o    ( pready        ),
    .prdata_o    ( prdata        ),
    .pslverr_o   ( pslverr       ),
    .timer_irq_o ( timer_irq     ),
    .ipi_o       ( ipi           ),
    .debug_req_o ( debug_req_out )
  );

  // Cycles since time zero and since reset release
  always @(posedge clk) begin
    run_cycles <= run_cycles + 1;
    if (ndmreset_n) begin
      rel_cycles <= rel_cycles + 1;
    end
  end

  initial begin
    while (run_cycles < max_cycles) @(posedge clk);
    $display("Run timed out after %0d cycles", run_cycles);
    $display("SIMULATION FAILED");
    $finish;
  end

  // --------------------
  // Bus and pin tasks
  // --------------------
  task automatic apb_transfer(input logic wr, input logic [15:0] addr, input logic [31:0] data,
                              output logic [31:0] rdata, output logic err);
    int unsigned wait_cnt;
    logic        done;
    wait_cnt = 0;
    done     = 1'b0;
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= data;
    @(posedge clk);
    penable <= 1'b1;
    while (!done && wait_cnt < 8) begin
      @(negedge clk);
      if (pready) done = 1'b1;
      else wait_cnt++;
    end
    rdata = prdata;
    err   = pslverr;
    if (!done) begin
      $display("APB transfer to 0x%04h never saw pready", addr);
      err_cnt++;
    end else if (wait_cnt != 1) begin
      $display("ERR %0t: transfer to 0x%04h took %0d wait states, expected 1", $time, addr,
               wait_cnt);
      err_cnt++;
    end
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic run_write(input logic [15:0] addr, input logic [31:0] data, input logic exp_err);
    logic [31:0] rdata;
    logic        err;
    apb_transfer(1'b1, addr, data, rdata, err);
    if (err != exp_err) begin
      $display("ERR %0t: pslverr on write to 0x%04h is %0b, expected %0b", $time, addr, err,
               exp_err);
      err_cnt++;
    end
  endtask

  task automatic run_read(input logic [15:0] addr, input logic [31:0] exp_data,
                          input logic exp_err);
    logic [31:0] rdata;
    logic        err;
    apb_transfer(1'b0, addr, 32'h0, rdata, err);
    if (rdata != exp_data) begin
      $display("ERR %0t: read 0x%04h gave 0x%08h, expected 0x%08h", $time, addr, rdata,
               exp_data);
      err_cnt++;
    end
    if (err != exp_err) begin
      $display("ERR %0t: pslverr on read of 0x%04h is %0b, expected %0b", $time, addr, err,
               exp_err);
      err_cnt++;
    end
  endtask

  // Each rtc level lasts 8 cycles
  task automatic drive_rtc_edges(input int edges);
    for (int i = 0; i < edges; i++) begin
      @(posedge clk);
      rtc <= 1'b1;
      repeat (8) @(posedge clk);
      rtc <= 1'b0;
      repeat (7) @(posedge clk);
    end
  endtask

  task automatic check_irq_lines(input logic [NumHarts-1:0] exp_tirq,
                                 input logic [NumHarts-1:0] exp_ipi);
    repeat (4) @(posedge clk);
    @(negedge clk);
    if (timer_irq != exp_tirq) begin
      $display("ERR %0t: timer_irq_o is %b, expected %b", $time, timer_irq, exp_tirq);
      err_cnt++;
    end
    if (ipi != exp_ipi) begin
      $display("ERR %0t: ipi_o is %b, expected %b", $time, ipi, exp_ipi);
      err_cnt++;
    end
  endtask

  // First high DbgHoldoffCycles+1 cycles after release
  task automatic check_debug_holdoff();
    if (rel_cycles > HoldoffCycles - 2) begin
      $display("Hold-off check started too late, at cycle %0d after reset", rel_cycles);
      err_cnt++;
    end
    while (rel_cycles < HoldoffCycles - 2) @(negedge clk);
    if (debug_req_out != '0) begin
      $display("ERR %0t: debug_req_o is %b at cycle %0d", $time, debug_req_out, rel_cycles);
      err_cnt++;
    end
    while (rel_cycles < HoldoffCycles + 3) @(negedge clk);
    repeat (5) begin
      if (debug_req_out != '1) begin
        $display("ERR %0t: debug_req_o is %b at cycle %0d", $time, debug_req_out, rel_cycles);
        err_cnt++;
      end
      @(negedge clk);
    end
  endtask

  task automatic check_field_count(input int got, input int want, input string line);
    if (got != want) begin
      $display("Stimulus line has %0d fields instead of %0d: %s", got, want, line);
      err_cnt++;
    end
  endtask

  task automatic report_test(input string desc, input int errs_before);
    test_cnt++;
    $display("test %0d %s: %s", test_cnt, desc, (err_cnt == errs_before) ? "ok" : "failed");
  endtask

  // --------------------
  // Main sequence
  // --------------------
  initial begin
    int          fd;
    int          n;
    int          total_lines;
    int          errs_before;
    int          edges;
    string       line;
    logic [7:0]  op;
    logic [15:0] addr_f;
    logic [31:0] data_f;
    logic        err_f;
    logic [1:0]  tirq_f;
    logic [1:0]  ipi_f;
    total_lines = 0;
    rtc       = 1'b0;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    paddr     = '0;
    pwdata    = '0;
    debug_req = '1;
    fd = $fopen("dv/clint_input.txt", "r");
    if (fd == 0) begin
      $display("Cannot open stimulus file dv/clint_input.txt");
      err_cnt++;
    end else begin
      while ($fgets(line, fd) != 0) total_lines++;
      $fclose(fd);
      max_cycles = 64 * total_lines + HoldoffCycles + 1000;
      fd = $fopen("dv/clint_input.txt", "r");
      wait (ndmreset_n == 1'b1);
      while ($fgets(line, fd) != 0) begin
        if (line.len() > 1 && line[0] != "#") begin
          errs_before = err_cnt;
          n = $sscanf(line, "%c", op);
          case (op)
            "W": begin
              n = $sscanf(line, "%c %h %h %h", op, addr_f, data_f, err_f);
              check_field_count(n, 4, line);
              run_write(addr_f, data_f, err_f);
              report_test($sformatf("write 0x%04h 0x%08h", addr_f, data_f), errs_before);
            end
            "R": begin
              n = $sscanf(line, "%c %h %h %h", op, addr_f, data_f, err_f);
              check_field_count(n, 4, line);
              run_read(addr_f, data_f, err_f);
              report_test($sformatf("read 0x%04h", addr_f), errs_before);
            end
            "T": begin
              n = $sscanf(line, "%c %d", op, edges);
              check_field_count(n, 2, line);
              drive_rtc_edges(edges);
              report_test($sformatf("%0d rtc edges", edges), errs_before);
            end
            "I": begin
              n = $sscanf(line, "%c %h %h", op, tirq_f, ipi_f);
              check_field_count(n, 3, line);
              check_irq_lines(tirq_f, ipi_f);
              report_test($sformatf("irq lines %b %b", tirq_f, ipi_f), errs_before);
            end
            "D": begin
              check_debug_holdoff();
              report_test("debug hold-off", errs_before);
            end
            default: begin
              $display("Unknown operation in stimulus line: %s", line);
              err_cnt++;
            end
          endcase
        end
      end
      $fclose(fd);
    end
    $display("%0d tests run, %0d errors", test_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: dv/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen #(
  parameter int unsigned PeriodNs    = 100,
  parameter int unsigned ResetCycles = 3
) (
  output logic clk_o,
  output logic ndmreset_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PeriodNs / 2) clk_o = !clk_o;
  end

  // Release on a rising edge so the flops see reset for full cycles
  initial begin
    ndmreset_n_o = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    ndmreset_n_o <= 1'b1;
  end

endmodule

// File: source/clint_subsystem.sv
`timescale 1ns/1ns

module clint_subsystem #(
  parameter int unsigned NumHarts         = 2,
  parameter int unsigned DbgHoldoffCycles = 500
) (
  input  logic                               clk_i,
  input  logic                               ndmreset_n,
  input  logic                               rtc_i,
  input  logic                               psel_i,
  input  logic                               penable_i,
  input  logic                               pwrite_i,
  input  logic [clint_pkg::ApbAddrWidth-1:0] paddr_i,
  input  logic [clint_pkg::ApbDataWidth-1:0] pwdata_i,
  input  logic [NumHarts-1:0]                debug_req_i,
  output logic                               pready_o,
  output logic [clint_pkg::ApbDataWidth-1:0] prdata_o,
  output logic                               pslverr_o,
  output logic [NumHarts-1:0]                timer_irq_o,
  output logic [NumHarts-1:0]                ipi_o,
  output logic [NumHarts-1:0]                debug_req_o
);

  logic [NumHarts-1:0]                              hart_wr;
  clint_pkg::reg_sel_e                              reg_sel;
  logic [clint_pkg::ApbDataWidth-1:0]               wdata;
  logic                                             mtime_wr_lo;
  logic                                             mtime_wr_hi;
  logic [clint_pkg::MtimeWidth-1:0]                 mtime;
  logic [NumHarts-1:0][clint_pkg::ApbDataWidth-1:0] hart_rdata;
  logic [NumHarts-1:0]                              timer_hit;
  logic [NumHarts-1:0]                              msip;

  clint_apb_decoder #(
    .NumHarts      ( NumHarts    )
  ) i_clint_apb_decoder (
    .clk_i         ( clk_i       ),
    .ndmreset_n    ( ndmreset_n  ),
    .psel_i        ( psel_i      ),
    .penable_i     ( penable_i   ),
    .pwrite_i      ( pwrite_i    ),
    .paddr_i       ( paddr_i     ),
    .pwdata_i      ( pwdata_i    ),
    .hart_rdata_i  ( hart_rdata  ),
    .mtime_i       ( mtime       ),
    .pready_o      ( pready_o    ),
    .prdata_o      ( prdata_o    ),
    .pslverr_o     ( pslverr_o   ),
    .hart_wr_o     ( hart_wr     ),
    .reg_sel_o     ( reg_sel     ),
    .wdata_o       ( wdata       ),
    .mtime_wr_lo_o ( mtime_wr_lo ),
    .mtime_wr_hi_o ( mtime_wr_hi )
  );

  mtime_counter i_mtime_counter (
    .clk_i      ( clk_i       ),
    .ndmreset_n ( ndmreset_n  ),
    .rtc_i      ( rtc_i       ),
    .wr_lo_i    ( mtime_wr_lo ),
    .wr_hi_i    ( mtime_wr_hi ),
    .wdata_i    ( wdata       ),
    .mtime_o    ( mtime       )
  );

  for (genvar h = 0; h < NumHarts; h++) begin : gen_hart
    clint_hart_timer i_clint_hart_timer (
      .clk_i       ( clk_i         ),
      .ndmreset_n  ( ndmreset_n    ),
      .wr_i        ( hart_wr[h]    ),
      .reg_sel_i   ( reg_sel       ),
      .wdata_i     ( wdata         ),
      .mtime_i     ( mtime         ),
      .rdata_o     ( hart_rdata[h] ),
      .timer_hit_o ( timer_hit[h]  ),
      .msip_o      ( msip[h]       )
    );
  end

  irq_collector #(
    .NumHarts         ( NumHarts         ),
    .DbgHoldoffCycles ( DbgHoldoffCycles )
  ) i_irq_collector (
    .clk_i            ( clk_i            ),
    .ndmreset_n       ( ndmreset_n       ),
    .timer_hit_i      ( timer_hit        ),
    .msip_i           ( msip             ),
    .debug_req_i      ( debug_req_i      ),
    .timer_irq_o      ( timer_irq_o      ),
    .ipi_o            ( ipi_o            ),
    .debug_req_o      ( debug_req_o      )
  );

endmodule

// File: source/irq_collector.sv
`timescale 1ns/1ns

module irq_collector #(
  parameter int unsigned NumHarts         = 2,
  parameter int unsigned DbgHoldoffCycles = 500
) (
  input  logic                clk_i,
  input  logic                ndmreset_n,
  input  logic [NumHarts-1:0] timer_hit_i,
  input  logic [NumHarts-1:0] msip_i,
  input  logic [NumHarts-1:0] debug_req_i,
  output logic [NumHarts-1:0] timer_irq_o,
  output logic [NumHarts-1:0] ipi_o,
  output logic [NumHarts-1:0] debug_req_o
);

  localparam int unsigned CntWidth = (DbgHoldoffCycles > 0) ? $clog2(DbgHoldoffCycles + 1) : 1;

  logic [CntWidth-1:0] holdoff_q;
  logic [NumHarts-1:0] timer_irq_q;
  logic [NumHarts-1:0] ipi_q;
  logic [NumHarts-1:0] debug_req_q;

  // --------------------
  // Interrupt lines
  // --------------------
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      timer_irq_q <= '0;
      ipi_q       <= '0;
    end else begin
      timer_irq_q <= timer_hit_i;
      ipi_q       <= msip_i;
    end
  end

  // --------------------
  // Debug hold-off
  // --------------------
  // Gives the harts time to run boot code before a halt
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      holdoff_q   <= CntWidth'(DbgHoldoffCycles);
      debug_req_q <= '0;
    end else begin
      if (holdoff_q != '0) begin
        holdoff_q <= holdoff_q - 1'b1;
      end
      debug_req_q <= (holdoff_q != '0) ? '0 : debug_req_i;
    end
  end

  assign timer_irq_o = timer_irq_q;
  assign ipi_o       = ipi_q;
  assign debug_req_o = debug_req_q;

  a_holdoff_masks: assert property (
    @(posedge clk_i) disable iff (!ndmreset_n)
    (holdoff_q != '0) |-> (debug_req_o == '0));

endmodule

// File: source/mtime_counter.sv
`timescale 1ns/1ns

module mtime_counter (
  input  logic                               clk_i,
  input  logic                               ndmreset_n,
  input  logic                               rtc_i,
  input  logic                               wr_lo_i,
  input  logic                               wr_hi_i,
  input  logic [clint_pkg::ApbDataWidth-1:0] wdata_i,
  output logic [clint_pkg::MtimeWidth-1:0]   mtime_o
);

  logic [2:0]                       rtc_sync_q;
  logic                             rtc_rise;
  logic                             div_q;
  logic                             tick_q;
  logic [clint_pkg::MtimeWidth-1:0] mtime_q;

  // Two-flop synchronizer, third stage for edge detect
  assign rtc_rise = rtc_sync_q[1] && !rtc_sync_q[2];

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      rtc_sync_q <= '0;
      div_q      <= 1'b0;
      tick_q     <= 1'b0;
    end else begin
      rtc_sync_q <= {rtc_sync_q[1:0], rtc_i};
      // Every second edge gives a tick
      if (rtc_rise) begin
        div_q <= !div_q;
      end
      tick_q <= rtc_rise && div_q;
    end
  end

  // Writes win over a tick
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      mtime_q <= '0;
    end else if (wr_lo_i || wr_hi_i) begin
      if (wr_lo_i) mtime_q[31:0]  <= wdata_i;
      if (wr_hi_i) mtime_q[63:32] <= wdata_i;
    end else if (tick_q) begin
      mtime_q <= mtime_q + 64'd1;
    end
  end

  assign mtime_o = mtime_q;

  a_step_one: assert property (
    @(posedge clk_i) disable iff (!ndmreset_n)
    !(wr_lo_i || wr_hi_i) |=> (mtime_q == $past(mtime_q)) || (mtime_q == $past(mtime_q) + 64'd1));

endmodule
